// File: hdl/clic_arbiter.sv
// CLIC arbiter
// Latches source pulses as pending bits, picks the highest level pending
// source and presents it to the hart. Requests a kill when a higher level
// source shows up behind the presented one.

`timescale 1ns/1ps

module clic_arbiter import clic_pkg::*; #(
  parameter int NumSrc = 16
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic [NumSrc-1:0]           src_pulse_i,
  input  logic [NumSrc*LVL_W-1:0]     src_level_i,
  input  priv_lvl_e [NumSrc-1:0]      src_priv_i,
  input  logic [NumSrc-1:0]           src_v_i,
  input  logic [NumSrc*VSID_W-1:0]    src_vsid_i,
  input  logic                        irq_ready_i,
  input  logic                        clic_kill_ack_i,
  output logic                        clic_irq_valid_o,
  output logic [$clog2(NumSrc)-1:0]   clic_irq_id_o,
  output logic [LVL_W-1:0]            clic_irq_level_o,
  output priv_lvl_e                   clic_irq_priv_o,
  output logic                        clic_irq_v_o,
  output logic [VSID_W-1:0]           clic_irq_vsid_o,
  output logic                        clic_kill_req_o
);

  localparam int IdW = $clog2(NumSrc);

  logic [NumSrc-1:0] pend_q, clr_mask;
  logic              best_valid;
  logic [IdW-1:0]    best_id;
  logic [LVL_W-1:0]  best_lvl;
  logic              valid_q, kill_req_q;
  logic              taken, load, beat;

  // ------------------------------------------------------------------
  // Pending bits
  // ------------------------------------------------------------------
  assign taken    = valid_q & irq_ready_i;  // Presented irq acknowledged
  assign clr_mask = NumSrc'(taken) << clic_irq_id_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q <= '0;
    end else begin
      pend_q <= (pend_q & ~clr_mask) | src_pulse_i;  // New pulse wins over clear
    end
  end

  // Highest level scan, ascending ids so the lowest id keeps a tie
  always_comb begin
    best_valid = 1'b0;
    best_id    = '0;
    best_lvl   = '0;
    for (int i = 0; i < NumSrc; i++) begin
      if (pend_q[i] && (!best_valid || src_level_i[i*LVL_W +: LVL_W] > best_lvl)) begin
        best_valid = 1'b1;
        best_id    = IdW'(i);
        best_lvl   = src_level_i[i*LVL_W +: LVL_W];
      end
    end
  end

  // ------------------------------------------------------------------
  // Presented interrupt
  // ------------------------------------------------------------------
  // Reload when idle or released by a kill, never on the ack edge
  assign load = (!valid_q || clic_kill_ack_i) && !taken;
  assign beat = valid_q && best_valid && (best_lvl > clic_irq_level_o);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q    <= 1'b0;
      kill_req_q <= 1'b0;
    end else begin
      if (taken) valid_q <= 1'b0;
      else if (load) valid_q <= best_valid;
      // Kill request held until the pipeline lets go
      if (clic_kill_ack_i) kill_req_q <= 1'b0;
      else if (beat && !irq_ready_i) kill_req_q <= 1'b1;
    end
  end

  // Payload of the presented source
  always_ff @(posedge clk_i) begin
    if (load) begin
      clic_irq_id_o    <= best_id;
      clic_irq_level_o <= best_lvl;
      clic_irq_priv_o  <= src_priv_i[best_id];
      clic_irq_v_o     <= src_v_i[best_id];
      clic_irq_vsid_o  <= src_vsid_i[best_id*VSID_W +: VSID_W];
    end
  end

  assign clic_irq_valid_o = valid_q;
  assign clic_kill_req_o  = kill_req_q;

  // Presented source must still be pending
  a_present_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_q |-> pend_q[clic_irq_id_o]);

  // Kill request and the presented source both held until the ack
  a_kill_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    kill_req_q && valid_q && !clic_kill_ack_i && !irq_ready_i |=>
      kill_req_q && $stable(clic_irq_id_o));

endmodule

// File: hdl/clic_hart_regs.sv
// Hart interrupt state
// Privilege, thresholds, mintstatus levels and enables as a CSR file would
// hold them. Written by opcode, in-service level raised on acknowledge.

`timescale 1ns/1ps

module clic_hart_regs import clic_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              reg_we_i,
  input  reg_op_e           reg_op_i,
  input  logic [XLEN-1:0]   reg_wdata_i,
  input  logic              irq_ready_i,
  input  priv_lvl_e         irq_priv_i,
  input  logic              irq_v_i,
  input  logic [LVL_W-1:0]  irq_level_i,
  output priv_lvl_e         priv_lvl_o,
  output logic              v_o,
  output logic [LVL_W-1:0]  mintthresh_o,
  output logic [LVL_W-1:0]  sintthresh_o,
  output logic [LVL_W-1:0]  vsintthresh_o,
  output logic [LVL_W-1:0]  mil_o,
  output logic [LVL_W-1:0]  sil_o,
  output logic [LVL_W-1:0]  vsil_o,
  output logic              sie_o,
  output logic              vsie_o,
  output logic              sgeie_o,
  output logic [XLEN-1:0]   hgeie_o,
  output logic [VSID_W-1:0] vgein_o
);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      priv_lvl_o    <= PRIV_LVL_M;  // Out of reset in M mode
      v_o           <= 1'b0;
      mintthresh_o  <= '0;
      sintthresh_o  <= '0;
      vsintthresh_o <= '0;
      mil_o         <= '0;
      sil_o         <= '0;
      vsil_o        <= '0;
      sie_o         <= 1'b0;
      vsie_o        <= 1'b0;
      sgeie_o       <= 1'b0;
      hgeie_o       <= '0;
      vgein_o       <= '0;
    end else begin
      // Taken irq enters service at its own level
      if (irq_ready_i) begin
        if (irq_priv_i == PRIV_LVL_M) mil_o <= irq_level_i;
        else if (irq_v_i) vsil_o <= irq_level_i;
        else sil_o <= irq_level_i;
      end
      // Software write, later assignment wins
      if (reg_we_i) begin
        unique case (reg_op_i)
          OP_PRIV: begin
            priv_lvl_o <= priv_lvl_e'(reg_wdata_i[1:0]);
            v_o        <= reg_wdata_i[2];
          end
          OP_MTHRESH:  mintthresh_o  <= reg_wdata_i[LVL_W-1:0];
          OP_STHRESH:  sintthresh_o  <= reg_wdata_i[LVL_W-1:0];
          OP_VSTHRESH: vsintthresh_o <= reg_wdata_i[LVL_W-1:0];
          OP_MIL:      mil_o         <= reg_wdata_i[LVL_W-1:0];
          OP_SIL:      sil_o         <= reg_wdata_i[LVL_W-1:0];
          OP_VSIL:     vsil_o        <= reg_wdata_i[LVL_W-1:0];
          OP_ENABLES: begin
            sie_o   <= reg_wdata_i[0];
            vsie_o  <= reg_wdata_i[1];
            sgeie_o <= reg_wdata_i[2];
          end
          OP_HGEIE:    hgeie_o       <= reg_wdata_i;
          OP_VGEIN:    vgein_o       <= reg_wdata_i[VSID_W-1:0];
          default: ;  // Unused opcodes ignored
        endcase
      end
    end
  end

endmodule

// File: hdl/clic_irq_ctrl.sv
// CLIC acceptance block
// Decides from hart mode, thresholds and in-service levels whether the
// presented interrupt is taken, packs the cause word and answers kills.

`timescale 1ns/1ps

module clic_irq_ctrl import clic_pkg::*; #(
  parameter int NumSrc = 16
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Hart state
  input  priv_lvl_e                 priv_lvl_i,
  input  logic                      v_i,
  input  logic [LVL_W-1:0]          mintthresh_i,
  input  logic [LVL_W-1:0]          sintthresh_i,
  input  logic [LVL_W-1:0]          vsintthresh_i,
  input  logic [LVL_W-1:0]          mil_i,
  input  logic [LVL_W-1:0]          sil_i,
  input  logic [LVL_W-1:0]          vsil_i,
  input  logic                      sie_i,
  input  logic                      vsie_i,
  input  logic                      sgeie_i,
  input  logic [XLEN-1:0]           hgeie_i,
  input  logic [VSID_W-1:0]         vgein_i,
  // Presented interrupt
  input  logic                      clic_irq_valid_i,
  input  logic                      clic_irq_ready_i,
  input  logic [$clog2(NumSrc)-1:0] clic_irq_id_i,
  input  logic [LVL_W-1:0]          clic_irq_level_i,
  input  priv_lvl_e                 clic_irq_priv_i,
  input  logic                      clic_irq_v_i,
  input  logic [VSID_W-1:0]         clic_irq_vsid_i,
  input  logic                      clic_kill_req_i,
  output logic                      clic_kill_ack_o,
  // To pipeline
  output logic                      clic_irq_req_o,
  output priv_lvl_e                 clic_irq_priv_o,
  output logic                      clic_irq_v_o,
  output logic [XLEN-1:0]           clic_irq_cause_o
);

  localparam int IdW = $clog2(NumSrc);

  logic [LVL_W-1:0] m_thr, s_thr, vs_thr;
  logic             inflight_q;
  logic             above_m, above_s, above_vs;

  function automatic logic [LVL_W-1:0] max_lvl(input logic [LVL_W-1:0] a,
                                                input logic [LVL_W-1:0] b);
    return (a > b) ? a : b;
  endfunction

  // ------------------------------------------------------------------
  // Effective thresholds
  // ------------------------------------------------------------------
  assign m_thr    = max_lvl(mintthresh_i, mil_i);   // In-service level raises the bar
  assign s_thr    = max_lvl(sintthresh_i, sil_i);
  assign vs_thr   = max_lvl(vsintthresh_i, vsil_i);
  assign above_m  = clic_irq_level_i > m_thr;
  assign above_s  = clic_irq_level_i > s_thr;
  assign above_vs = clic_irq_level_i > vs_thr;

  // ------------------------------------------------------------------
  // Acceptance
  // ------------------------------------------------------------------
  always_comb begin
    clic_irq_priv_o = clic_irq_priv_i;
    clic_irq_v_o    = 1'b0;
    clic_irq_req_o  = 1'b0;
    unique case (priv_lvl_i)
      PRIV_LVL_M: begin
        // Only higher M interrupts
        clic_irq_req_o = clic_irq_valid_i && (clic_irq_priv_i == PRIV_LVL_M) && above_m;
      end
      PRIV_LVL_S: begin
        if (clic_irq_priv_i == PRIV_LVL_M) begin
          clic_irq_req_o = clic_irq_valid_i;  // M always preempts S
        end else if (clic_irq_priv_i == PRIV_LVL_S) begin
          if (v_i && clic_irq_v_i) begin
            if (clic_irq_vsid_i == vgein_i) begin
              // Guest currently running
              clic_irq_req_o = clic_irq_valid_i && above_vs && vsie_i;
              clic_irq_v_o   = 1'b1;
            end else begin
              // Other guest, trap to hypervisor
              clic_irq_req_o = clic_irq_valid_i && sgeie_i && hgeie_i[clic_irq_vsid_i];
            end
          end else if (v_i) begin
            clic_irq_req_o = clic_irq_valid_i && above_s;  // Host S, sie implied
          end else if (!clic_irq_v_i) begin
            clic_irq_req_o = clic_irq_valid_i && above_s && sie_i;
          end
          // Virtual irq in HS mode dropped
        end
      end
      PRIV_LVL_U: begin
        clic_irq_req_o = clic_irq_valid_i &&
                         ((clic_irq_priv_i == PRIV_LVL_M) ||
                          (clic_irq_priv_i == PRIV_LVL_S && sie_i));
      end
      default: ;  // Reserved mode takes nothing
    endcase
  end

  // Cause word: flag, level, id
  always_comb begin
    clic_irq_cause_o                               = '0;
    clic_irq_cause_o[CAUSE_IRQ_BIT]                = 1'b1;
    clic_irq_cause_o[CAUSE_LVL_LSB +: LVL_W]       = clic_irq_level_i;
    clic_irq_cause_o[IdW-1:0]                      = clic_irq_id_i;
  end

  // ------------------------------------------------------------------
  // Kill handshake
  // ------------------------------------------------------------------
  // No kill while an irq sits in the pipeline or is taken right now
  assign clic_kill_ack_o = clic_kill_req_i & ~inflight_q & ~clic_irq_req_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inflight_q <= 1'b0;
    end else if (inflight_q) begin
      inflight_q <= ~clic_irq_ready_i;  // Only the pipeline ack ends it
    end else begin
      inflight_q <= clic_irq_req_o & ~clic_irq_ready_i;  // Acked at once, never in flight
    end
  end

  // An irq handed over and not yet acked is never killed next cycle
  a_no_kill_inflight: assert property (@(posedge clk_i) disable iff (!rst_ni)
    clic_irq_req_o && !clic_irq_ready_i |=> !clic_kill_ack_o);

endmodule

// File: hdl/clic_pkg.sv
// CLIC shared definitions
// Widths, privilege and register-write opcode enums, cause word layout

package clic_pkg;

  // ------------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------------
  localparam int XLEN           = 64;  // Cause word and CSR data width
  localparam int LVL_W          = 8;   // Interrupt level
  localparam int VSID_W         = 6;   // Virtual supervisor id
  localparam int CAUSE_ID_FIELD = 16;  // Id field reserved in cause

  // Cause word layout
  localparam int CAUSE_IRQ_BIT = XLEN - 1;        // Interrupt flag
  localparam int CAUSE_LVL_LSB = CAUSE_ID_FIELD;  // Level sits above id field

  // ------------------------------------------------------------------
  // Enums
  // ------------------------------------------------------------------
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11  // 2'b10 reserved, never accepted
  } priv_lvl_e;

  typedef enum logic [3:0] {
    OP_PRIV     = 4'd0,  // priv in [1:0], v in [2]
    OP_MTHRESH  = 4'd1,
    OP_STHRESH  = 4'd2,
    OP_VSTHRESH = 4'd3,
    OP_MIL      = 4'd4,
    OP_SIL      = 4'd5,
    OP_VSIL     = 4'd6,
    OP_ENABLES  = 4'd7,  // sie [0], vsie [1], sgeie [2]
    OP_HGEIE    = 4'd8,  // Full 64 bit mask
    OP_VGEIN    = 4'd9   // Guest id of running VS
  } reg_op_e;

endpackage

// File: hdl/clic_top.sv
// CLIC subsystem top
// Arbiter, acceptance block and hart state registers wired together

`timescale 1ns/1ps

module clic_top import clic_pkg::*; #(
  parameter int NumSrc = 16
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic [NumSrc-1:0]        src_pulse_i,
  input  logic [NumSrc*LVL_W-1:0]  src_level_i,
  input  priv_lvl_e [NumSrc-1:0]   src_priv_i,
  input  logic [NumSrc-1:0]        src_v_i,
  input  logic [NumSrc*VSID_W-1:0] src_vsid_i,
  input  logic                     reg_we_i,
  input  reg_op_e                  reg_op_i,
  input  logic [XLEN-1:0]          reg_wdata_i,
  input  logic                     irq_ready_i,
  output logic                     irq_req_o,
  output priv_lvl_e                irq_priv_o,
  output logic                     irq_v_o,
  output logic [XLEN-1:0]          irq_cause_o
);

  localparam int IdW = $clog2(NumSrc);

  // Arbiter to acceptance block
  logic              clic_irq_valid, clic_irq_v, clic_kill_req, clic_kill_ack;
  logic [IdW-1:0]    clic_irq_id;
  logic [LVL_W-1:0]  clic_irq_level;
  priv_lvl_e         clic_irq_priv;
  logic [VSID_W-1:0] clic_irq_vsid;

  // Hart state
  priv_lvl_e         priv_lvl;
  logic              v, sie, vsie, sgeie;
  logic [LVL_W-1:0]  mintthresh, sintthresh, vsintthresh, mil, sil, vsil;
  logic [XLEN-1:0]   hgeie;
  logic [VSID_W-1:0] vgein;

  clic_arbiter #(.NumSrc(NumSrc)) u_arbiter (
    .clk_i, .rst_ni, .src_pulse_i, .src_level_i, .src_priv_i, .src_v_i, .src_vsid_i,
    .irq_ready_i,
    .clic_kill_ack_i  (clic_kill_ack),
    .clic_irq_valid_o (clic_irq_valid),
    .clic_irq_id_o    (clic_irq_id),
    .clic_irq_level_o (clic_irq_level),
    .clic_irq_priv_o  (clic_irq_priv),
    .clic_irq_v_o     (clic_irq_v),
    .clic_irq_vsid_o  (clic_irq_vsid),
    .clic_kill_req_o  (clic_kill_req)
  );

  clic_irq_ctrl #(.NumSrc(NumSrc)) u_irq_ctrl (
    .clk_i, .rst_ni,
    .priv_lvl_i (priv_lvl), .v_i (v),
    .mintthresh_i (mintthresh), .sintthresh_i (sintthresh), .vsintthresh_i (vsintthresh),
    .mil_i (mil), .sil_i (sil), .vsil_i (vsil),
    .sie_i (sie), .vsie_i (vsie), .sgeie_i (sgeie), .hgeie_i (hgeie), .vgein_i (vgein),
    .clic_irq_valid_i (clic_irq_valid),
    .clic_irq_ready_i (irq_ready_i),
    .clic_irq_id_i    (clic_irq_id),
    .clic_irq_level_i (clic_irq_level),
    .clic_irq_priv_i  (clic_irq_priv),
    .clic_irq_v_i     (clic_irq_v),
    .clic_irq_vsid_i  (clic_irq_vsid),
    .clic_kill_req_i  (clic_kill_req),
    .clic_kill_ack_o  (clic_kill_ack),
    .clic_irq_req_o   (irq_req_o),
    .clic_irq_priv_o  (irq_priv_o),
    .clic_irq_v_o     (irq_v_o),
    .clic_irq_cause_o (irq_cause_o)
  );

  clic_hart_regs u_hart_regs (
    .clk_i, .rst_ni, .reg_we_i, .reg_op_i, .reg_wdata_i, .irq_ready_i,
    .irq_priv_i (irq_priv_o), .irq_v_i (irq_v_o), .irq_level_i (clic_irq_level),
    .priv_lvl_o (priv_lvl), .v_o (v),
    .mintthresh_o (mintthresh), .sintthresh_o (sintthresh), .vsintthresh_o (vsintthresh),
    .mil_o (mil), .sil_o (sil), .vsil_o (vsil),
    .sie_o (sie), .vsie_o (vsie), .sgeie_o (sgeie), .hgeie_o (hgeie), .vgein_o (vgein)
  );

endmodule

// File: verification/clic_ref_model.svh
// CLIC reference model
// Acceptance rule, cause word layout and the LFSR used for stimulus

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// Cause word: interrupt flag, level in 23:16, id in the low bits
function automatic logic [63:0] ref_cause(input int id, input logic [7:0] lvl);
  logic [63:0] w;
  w        = '0;
  w[63]    = 1'b1;
  w[23:16] = lvl;
  w[15:0]  = id[15:0];
  return w;
endfunction

function automatic logic ref_accept(
  input priv_lvl_e mode, input logic virt,
  input logic [7:0] mth, input logic [7:0] sth, input logic [7:0] vsth,
  input logic [7:0] mil, input logic [7:0] sil, input logic [7:0] vsil,
  input logic sie, input logic vsie, input logic sgeie,
  input logic [63:0] hgeie, input logic [5:0] vgein,
  input priv_lvl_e spriv, input logic sv, input logic [5:0] svsid,
  input logic [7:0] lvl, output logic take_v);
  logic [7:0] m_thr, s_thr, vs_thr;
  logic       take;
  m_thr  = (mth > mil) ? mth : mil;    // Effective threshold per mode
  s_thr  = (sth > sil) ? sth : sil;
  vs_thr = (vsth > vsil) ? vsth : vsil;
  take   = 1'b0;
  take_v = 1'b0;
  case (mode)
    PRIV_LVL_M: take = (spriv == PRIV_LVL_M) && (lvl > m_thr);
    PRIV_LVL_S: begin
      if (spriv == PRIV_LVL_M) begin
        take = 1'b1;
      end else if (spriv == PRIV_LVL_S) begin
        if (virt && sv && svsid == vgein) begin
          take_v = 1'b1;  // Running guest
          take   = vsie && (lvl > vs_thr);
        end else if (virt && sv) begin
          take = sgeie && hgeie[svsid];
        end else if (virt || !sv) begin
          take = (virt || sie) && (lvl > s_thr);
        end
      end
    end
    PRIV_LVL_U: take = (spriv == PRIV_LVL_M) || (spriv == PRIV_LVL_S && sie);
    default: take = 1'b0;
  endcase
  return take;
endfunction

// File: verification/clic_tb.sv
// CLIC subsystem testbench
// Random hart state and source attributes, one source in flight at a time,
// plus a directed preemption case

`timescale 1ns/1ps

module clic_tb import clic_pkg::*;;

  localparam int NUM_SRC   = 16;
  localparam int RST_CYC   = 10;
  localparam int TRIALS    = 12;   // Per mode
  localparam int TRIAL_CYC = 40;   // Generous cycle budget per trial

  `include "clic_ref_model.svh"

  logic clk_i = 1'b0, rst_ni = 1'b0;
  logic [NUM_SRC-1:0]        src_pulse = '0;
  logic [NUM_SRC*LVL_W-1:0]  src_level = '0;
  priv_lvl_e [NUM_SRC-1:0]   src_priv;
  logic [NUM_SRC-1:0]        src_v = '0;
  logic [NUM_SRC*VSID_W-1:0] src_vsid = '0;
  logic reg_we = 1'b0, irq_ready = 1'b0;
  reg_op_e reg_op = OP_PRIV;
  logic [XLEN-1:0] reg_wdata = '0;
  logic irq_req_o, irq_v_o;
  priv_lvl_e irq_priv_o;
  logic [XLEN-1:0] irq_cause_o;

  // Testbench mirror of the hart state
  priv_lvl_e h_priv = PRIV_LVL_M;
  logic h_v = 0, h_sie = 0, h_vsie = 0, h_sgeie = 0;
  logic [7:0] h_mth = 0, h_sth = 0, h_vsth = 0, h_mil = 0, h_sil = 0, h_vsil = 0;
  logic [63:0] h_hgeie = '0;
  logic [5:0] h_vgein = '0;
  logic [NUM_SRC-1:0] pend_m = '0;  // Pending mirror
  logic [31:0] lfsr_q = 32'h767c_b211;
  logic chk_en = 1'b0;
  int exp_id = 0;
  int errors = 0;

  clic_top #(.NumSrc(NUM_SRC)) uut (
    .clk_i, .rst_ni, .src_pulse_i(src_pulse), .src_level_i(src_level),
    .src_priv_i(src_priv), .src_v_i(src_v), .src_vsid_i(src_vsid),
    .reg_we_i(reg_we), .reg_op_i(reg_op), .reg_wdata_i(reg_wdata),
    .irq_ready_i(irq_ready), .irq_req_o, .irq_priv_o, .irq_v_o, .irq_cause_o
  );

  always #10 clk_i = ~clk_i;  // 20 ns period

  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);  // One step per bit
      r      = {r[62:0], lfsr_q[0]};
    end
    return r;
  endfunction

  function automatic logic model_req(input int id, output logic tv);
    return ref_accept(h_priv, h_v, h_mth, h_sth, h_vsth, h_mil, h_sil, h_vsil,
                      h_sie, h_vsie, h_sgeie, h_hgeie, h_vgein, src_priv[id],
                      src_v[id], src_vsid[id*VSID_W +: VSID_W],
                      src_level[id*LVL_W +: LVL_W], tv);
  endfunction

  // ------------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------------
  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h exp %h (id %0d)", name, got, exp, exp_id);
    end
  endtask

  task automatic check_priv(input string name, input priv_lvl_e got, input priv_lvl_e exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_cause(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h exp %h", name, got, exp);
    end
  endtask

  // Outputs sampled on the rising edge, before any register update
  always @(posedge clk_i) begin
    logic ev, er;
    if (rst_ni && chk_en) begin
      er = model_req(exp_id, ev);
      check_bit("irq_req_o", irq_req_o, er);
      check_bit("irq_v_o", irq_v_o, ev);
      check_priv("irq_priv_o", irq_priv_o, src_priv[exp_id]);
      check_cause("irq_cause_o", irq_cause_o,
                  ref_cause(exp_id, src_level[exp_id*LVL_W +: LVL_W]));
    end
  end

  // ------------------------------------------------------------------
  // Stimulus tasks
  // ------------------------------------------------------------------
  task automatic write_reg(input reg_op_e op, input logic [63:0] d);
    @(negedge clk_i);
    reg_we    = 1'b1;
    reg_op    = op;
    reg_wdata = d;
    case (op)
      OP_PRIV: begin
        h_priv = priv_lvl_e'(d[1:0]);
        h_v    = d[2];
      end
      OP_MTHRESH:  h_mth  = d[7:0];
      OP_STHRESH:  h_sth  = d[7:0];
      OP_VSTHRESH: h_vsth = d[7:0];
      OP_MIL:      h_mil  = d[7:0];
      OP_SIL:      h_sil  = d[7:0];
      OP_VSIL:     h_vsil = d[7:0];
      OP_ENABLES:  {h_sgeie, h_vsie, h_sie} = d[2:0];
      OP_HGEIE:    h_hgeie = d;
      OP_VGEIN:    h_vgein = d[5:0];
      default: ;
    endcase
    @(negedge clk_i);
    reg_we = 1'b0;
  endtask

  task automatic pulse_src(input int id);
    @(negedge clk_i);
    src_pulse[id] = 1'b1;
    pend_m[id]    = 1'b1;
    @(negedge clk_i);
    src_pulse = '0;
  endtask

  task automatic wait_valid(input int id);
    int n;
    n = 0;
    while (!uut.clic_irq_valid && n < 8) begin
      @(negedge clk_i);
      n++;
    end
    if (!uut.clic_irq_valid) begin
      errors++;
      $display("Timeout: no interrupt presented for source %0d", id);
    end
    exp_id = id;
    chk_en = 1'b1;
    repeat (2) @(negedge clk_i);  // Let the compare process look
  endtask

  // Acknowledge the presented source, in-service level of its mode rises
  task automatic ack_src(input int id);
    logic tv;
    void'(model_req(id, tv));
    irq_ready = 1'b1;
    @(negedge clk_i);
    irq_ready  = 1'b0;
    chk_en     = 1'b0;
    pend_m[id] = 1'b0;
    if (src_priv[id] == PRIV_LVL_M) h_mil = src_level[id*LVL_W +: LVL_W];
    else if (tv) h_vsil = src_level[id*LVL_W +: LVL_W];
    else h_sil = src_level[id*LVL_W +: LVL_W];
    check_bit("pending", uut.u_arbiter.pend_q[id], pend_m[id]);
  endtask

  // Watchdog
  initial begin
    #((RST_CYC + 4 * TRIALS * TRIAL_CYC + 200) * 20);
    $display("Timeout: run did not finish, errors %0d", errors);
    $display("Checks failed");
    $finish;
  end

  initial begin
    priv_lvl_e modes [4];
    logic      vbits [4];
    int        s;
    modes = '{PRIV_LVL_M, PRIV_LVL_S, PRIV_LVL_S, PRIV_LVL_U};
    vbits = '{1'b0, 1'b0, 1'b1, 1'b0};
    for (int i = 0; i < NUM_SRC; i++) begin
      src_level[i*LVL_W +: LVL_W]   = take_bits(8);
      src_priv[i]                   = take_bits(1) ? PRIV_LVL_M : PRIV_LVL_S;
      src_v[i]                      = take_bits(1);
      src_vsid[i*VSID_W +: VSID_W]  = take_bits(2);  // Few guests, frequent match
    end
    repeat (RST_CYC) @(negedge clk_i);
    rst_ni = 1'b1;

    // Random acceptance across all modes
    for (int m = 0; m < 4; m++) begin
      for (int t = 0; t < TRIALS; t++) begin
        write_reg(OP_PRIV, {61'd0, vbits[m], modes[m]});
        write_reg(OP_MTHRESH, take_bits(8));
        write_reg(OP_STHRESH, take_bits(8));
        write_reg(OP_VSTHRESH, take_bits(8));
        write_reg(OP_ENABLES, take_bits(3));
        write_reg(OP_VGEIN, take_bits(2));
        write_reg(OP_HGEIE, take_bits(64));
        if (t % 4 == 0) begin
          write_reg(OP_MIL, take_bits(8));
          write_reg(OP_SIL, take_bits(8));
          write_reg(OP_VSIL, take_bits(8));
        end
        s = take_bits(4);
        // Second pulse sees the in-service level left by the first ack
        repeat (2) begin
          pulse_src(s);
          wait_valid(s);
          ack_src(s);
        end
      end
    end

    // Preemption: untaken S source, then a higher level M source
    src_priv[0] = PRIV_LVL_S;
    src_level[0 +: LVL_W] = 8'h10;
    src_priv[1] = PRIV_LVL_M;
    src_level[LVL_W +: LVL_W] = 8'h80;
    write_reg(OP_PRIV, {61'd0, 1'b0, PRIV_LVL_M});
    write_reg(OP_MTHRESH, 64'h20);
    write_reg(OP_MIL, 64'h0);
    pulse_src(0);
    wait_valid(0);
    chk_en = 1'b0;
    pulse_src(1);
    s = 0;
    while (irq_cause_o[15:0] != 16'd1 && s < 10) begin
      @(negedge clk_i);
      s++;
    end
    if (irq_cause_o[15:0] != 16'd1) begin
      errors++;
      $display("Higher level source was not presented after the kill");
    end
    wait_valid(1);
    ack_src(1);
    @(negedge clk_i);
    wait_valid(0);
    ack_src(0);
    repeat (4) @(negedge clk_i);

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+verification
hdl/clic_pkg.sv
hdl/clic_arbiter.sv
hdl/clic_irq_ctrl.sv
hdl/clic_hart_regs.sv
hdl/clic_top.sv
verification/clic_tb.sv
